// ==== logic/ro_cfg.svh ====
`ifndef RO_CFG_SVH
`define RO_CFG_SVH

// tasks in flight, one thread each
`define RO_N_THREADS 8

// 32 outstanding line reads
`define RO_TAG_BITS 5

// 8-byte edges per 64-byte line
`define RO_LINE_EDGES 8

// goes in the arid bits above the tag
`define RO_STAGE_ID 2

`define RO_CFG_ADDR_BITS 8
`define RO_CFG_NEIGHBOR_BASE 8'h10

`endif

// ==== logic/ro_task_pkg.sv ====
package ro_task_pkg;

   typedef struct packed {
      logic [31:0] ts;
      logic [31:0] locale;
   } task_t;

   // parent task with its edge-offset range
   typedef struct packed {
      task_t       task_desc;
      logic [31:0] eo_begin;
      logic [31:0] eo_end;
   } ro_in_t;

   // one neighbor-array entry as stored in memory
   typedef struct packed {
      logic [31:0] weight;
      logic [31:0] neighbor;
   } edge_t;

endpackage

// ==== logic/ro_mem_pkg.sv ====
`include "ro_cfg.svh"

package ro_mem_pkg;

   typedef logic [$clog2(`RO_N_THREADS)-1:0] thread_t;
   typedef logic [`RO_TAG_BITS-1:0]          tag_t;
   typedef logic [`RO_LINE_EDGES-1:0]        edge_mask_t;
   typedef logic [`RO_LINE_EDGES*64-1:0]     line_t;

   typedef struct packed {
      logic [7-`RO_TAG_BITS:0] stage;
      tag_t                    tag;
   } id_t;

   // what is known about a line read while it is outstanding
   typedef struct packed {
      thread_t    thread;
      edge_mask_t mask;
   } mshr_t;

endpackage

// ==== logic/free_list.sv ====
`timescale 1ns/1ps

module free_list #(
   parameter type ELEM_T = logic [3:0],
   parameter int  DEPTH  = 16
) (
   input  logic  clk,
   input  logic  rstn,
   input  logic  push,
   input  ELEM_T push_id,
   input  logic  pop,
   output ELEM_T head,
   output logic  empty,
   output logic  full
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   ELEM_T            slots [DEPTH];
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W-1:0] wr_ptr;
   logic [CNT_W-1:0] count;

   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign head  = slots[rd_ptr];
   assign empty = (count == '0);
   assign full  = (count == CNT_W'(DEPTH));

   always_ff @(posedge clk) begin
      if (!rstn) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= CNT_W'(DEPTH);   // every id starts out free
         for (int i = 0; i < DEPTH; i++) begin
            slots[i] <= ELEM_T'(i);
         end
      end else begin
         if (push) begin
            slots[wr_ptr] <= push_id;
            wr_ptr        <= ptr_next(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_next(rd_ptr);
         end
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

// ==== logic/ro_issue.sv ====
`timescale 1ns/1ps
`include "ro_cfg.svh"

module ro_issue (
   input  logic                         clk,
   input  logic                         rstn,
   input  logic                         in_valid,
   output logic                         in_ready,
   input  ro_task_pkg::ro_in_t          in_task,
   output logic                         arvalid,
   input  logic                         arready,
   output logic [31:0]                  araddr,
   output ro_mem_pkg::id_t              arid,
   output logic [7:0]                   arlen,
   input  logic                         cfg_wvalid,
   input  logic [`RO_CFG_ADDR_BITS-1:0] cfg_waddr,
   input  logic [31:0]                  cfg_wdata,
   input  ro_mem_pkg::tag_t             tag_head,
   input  logic                         tag_empty,
   output logic                         tag_pop,
   input  ro_mem_pkg::thread_t          thr_head,
   input  logic                         thr_empty,
   output logic                         thr_pop,
   output logic                         alloc_valid,
   output ro_mem_pkg::thread_t          alloc_thread,
   output logic [31:0]                  alloc_count,
   input  ro_mem_pkg::thread_t          ctx_thread,
   output logic [31:0]                  ctx_ts,
   input  ro_mem_pkg::tag_t             mshr_tag,
   output ro_mem_pkg::mshr_t            mshr
);
   import ro_mem_pkg::*;

   localparam int LINE_BYTES = `RO_LINE_EDGES * 8;
   localparam int LINE_SHIFT = $clog2(LINE_BYTES);

   logic [31:0] base_addr;
   logic        busy;        // burst in progress
   logic [31:0] cur_addr;
   logic [31:0] cur_left;    // edges not yet requested
   thread_t     cur_thread;
   logic [31:0] in_count;
   logic        in_empty;
   logic        accept;
   logic        ar_fire;
   logic [31:0] first_edge;
   logic [31:0] line_end;
   logic        last_line;
   logic [31:0] line_edges;
   edge_mask_t  line_mask;
   logic [31:0] ctx_mem  [`RO_N_THREADS];
   mshr_t       mshr_mem [1 << `RO_TAG_BITS];

   assign in_count = in_task.eo_end - in_task.eo_begin;
   assign in_empty = (in_count == '0);
   assign in_ready = in_empty | (!busy & !thr_empty);
   assign accept   = in_valid & in_ready & !in_empty;   // empty ranges just drop

   assign thr_pop      = accept;
   assign alloc_valid  = accept;
   assign alloc_thread = thr_head;
   assign alloc_count  = in_count;

   // current line, edge index range inside it
   assign first_edge = 32'(cur_addr[LINE_SHIFT-1:3]);
   assign line_end   = first_edge + cur_left;
   assign last_line  = (line_end <= 32'(`RO_LINE_EDGES));
   assign line_edges = last_line ? cur_left : 32'(`RO_LINE_EDGES) - first_edge;

   always_comb begin
      for (int i = 0; i < `RO_LINE_EDGES; i++) begin
         line_mask[i] = (32'(i) >= first_edge) && (32'(i) < line_end);
      end
   end

   assign arvalid   = busy & !tag_empty;
   assign araddr    = {cur_addr[31:LINE_SHIFT], {LINE_SHIFT{1'b0}}};
   assign arid      = '{stage: `RO_STAGE_ID, tag: tag_head};
   assign arlen     = 8'd0;
   assign ar_fire   = arvalid & arready;
   assign tag_pop   = ar_fire;

   assign ctx_ts = ctx_mem[ctx_thread];
   assign mshr   = mshr_mem[mshr_tag];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         base_addr <= '0;
      end else if (cfg_wvalid && cfg_waddr == `RO_CFG_NEIGHBOR_BASE) begin
         base_addr <= cfg_wdata << 2;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         busy <= 1'b0;
      end else if (accept) begin
         busy <= 1'b1;
      end else if (ar_fire && last_line) begin
         busy <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         cur_addr          <= base_addr + (in_task.eo_begin << 3);
         cur_left          <= in_count;
         cur_thread        <= thr_head;
         ctx_mem[thr_head] <= in_task.task_desc.ts;
      end else if (ar_fire) begin
         cur_addr <= araddr + 32'(LINE_BYTES);   // next line, aligned
         cur_left <= cur_left - line_edges;
      end
   end

   always_ff @(posedge clk) begin
      if (ar_fire) begin
         mshr_mem[tag_head] <= '{thread: cur_thread, mask: line_mask};
      end
   end

endmodule

// ==== logic/ro_fill.sv ====
`timescale 1ns/1ps
`include "ro_cfg.svh"

module ro_fill (
   input  logic                clk,
   input  logic                rstn,
   input  logic                rvalid,
   output logic                rready,
   input  ro_mem_pkg::id_t     rid,
   input  ro_mem_pkg::line_t   rdata,
   output ro_mem_pkg::tag_t    mshr_tag,
   input  ro_mem_pkg::mshr_t   mshr,
   input  logic                alloc_valid,
   input  ro_mem_pkg::thread_t alloc_thread,
   input  logic [31:0]         alloc_count,
   output logic                edge_valid,
   input  logic                edge_ready,
   output ro_task_pkg::edge_t  edge_data,
   output ro_mem_pkg::thread_t edge_thread,
   output logic                edge_last,
   output logic                tag_push,
   output ro_mem_pkg::tag_t    tag_push_id,
   output logic                thr_push,
   output ro_mem_pkg::thread_t thr_push_id
);
   import ro_mem_pkg::*;

   localparam int IDX_W = $clog2(`RO_LINE_EDGES);

   logic             line_valid;
   line_t            line_data;
   tag_t             line_tag;
   thread_t          line_thread;
   edge_mask_t       line_mask;
   edge_mask_t       next_mask;
   logic [IDX_W-1:0] idx;
   logic             fire;
   logic [31:0]      remaining [`RO_N_THREADS];   // edges still to emit per thread

   assign rready   = !line_valid;
   assign mshr_tag = rid.tag;

   // lowest pending edge in the held line
   always_comb begin
      idx = '0;
      for (int i = `RO_LINE_EDGES - 1; i >= 0; i--) begin
         if (line_mask[i]) begin
            idx = IDX_W'(i);
         end
      end
      next_mask      = line_mask;
      next_mask[idx] = 1'b0;
   end

   assign edge_valid  = line_valid;
   assign edge_data   = line_data[idx*64 +: 64];
   assign edge_thread = line_thread;
   assign edge_last   = (remaining[line_thread] == 32'd1);
   assign fire        = edge_valid & edge_ready;

   assign tag_push    = fire & (next_mask == '0);
   assign tag_push_id = line_tag;
   assign thr_push    = fire & edge_last;
   assign thr_push_id = line_thread;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         line_valid <= 1'b0;
      end else if (rvalid & rready) begin
         line_valid <= 1'b1;
      end else if (tag_push) begin
         line_valid <= 1'b0;   // last edge of this line taken
      end
   end

   always_ff @(posedge clk) begin
      if (rvalid & rready) begin
         line_data   <= rdata;
         line_tag    <= rid.tag;
         line_thread <= mshr.thread;
         line_mask   <= mshr.mask;
      end else if (fire) begin
         line_mask <= next_mask;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < `RO_N_THREADS; i++) begin
            remaining[i] <= '0;
         end
      end else begin
         for (int i = 0; i < `RO_N_THREADS; i++) begin
            if (alloc_valid && alloc_thread == thread_t'(i)) begin
               remaining[i] <= alloc_count;
            end else if (fire && line_thread == thread_t'(i)) begin
               remaining[i] <= remaining[i] - 32'd1;
            end
         end
      end
   end

endmodule

// ==== logic/ro_child_gen.sv ====
`timescale 1ns/1ps

module ro_child_gen (
   input  logic                clk,
   input  logic                rstn,
   input  logic                edge_valid,
   output logic                edge_ready,
   input  ro_task_pkg::edge_t  edge_data,
   input  ro_mem_pkg::thread_t edge_thread,
   input  logic                edge_last,
   output ro_mem_pkg::thread_t ctx_thread,
   input  logic [31:0]         ctx_ts,
   output logic                out_valid,
   input  logic                out_ready,
   output ro_task_pkg::task_t  out_task,
   output logic                out_last
);

   // parent ts looked up by the edge's thread
   assign ctx_thread = edge_thread;
   assign edge_ready = !out_valid | out_ready;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         out_valid <= 1'b0;
      end else if (edge_valid & edge_ready) begin
         out_valid <= 1'b1;
      end else if (out_ready) begin
         out_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (edge_valid & edge_ready) begin
         out_task.ts     <= ctx_ts + edge_data.weight;
         out_task.locale <= edge_data.neighbor;
         out_last        <= edge_last;
      end
   end

endmodule

// ==== logic/ro_stage.sv ====
`timescale 1ns/1ps
`include "ro_cfg.svh"

module ro_stage (
   input  logic                         clk,
   input  logic                         rstn,
   input  logic                         in_valid,
   output logic                         in_ready,
   input  ro_task_pkg::ro_in_t          in_task,
   output logic                         arvalid,
   input  logic                         arready,
   output logic [31:0]                  araddr,
   output ro_mem_pkg::id_t              arid,
   output logic [7:0]                   arlen,
   input  logic                         rvalid,
   output logic                         rready,
   input  ro_mem_pkg::id_t              rid,
   input  ro_mem_pkg::line_t            rdata,
   output logic                         out_valid,
   input  logic                         out_ready,
   output ro_task_pkg::task_t           out_task,
   output logic                         out_last,
   input  logic                         cfg_wvalid,
   input  logic [`RO_CFG_ADDR_BITS-1:0] cfg_waddr,
   input  logic [31:0]                  cfg_wdata,
   output logic                         idle
);
   import ro_task_pkg::*;
   import ro_mem_pkg::*;

   tag_t        tag_head;
   logic        tag_empty;
   logic        tag_pop;
   logic        tag_push;
   tag_t        tag_push_id;
   thread_t     thr_head;
   logic        thr_empty;
   logic        thr_pop;
   logic        thr_push;
   thread_t     thr_push_id;
   logic        alloc_valid;
   thread_t     alloc_thread;
   logic [31:0] alloc_count;
   thread_t     ctx_thread;
   logic [31:0] ctx_ts;
   tag_t        mshr_tag;
   mshr_t       mshr;
   logic        edge_valid;
   logic        edge_ready;
   edge_t       edge_data;
   thread_t     edge_thread;
   logic        edge_last;

   ro_issue issue0 (
      .clk, .rstn, .in_valid, .in_ready, .in_task,
      .arvalid, .arready, .araddr, .arid, .arlen,
      .cfg_wvalid, .cfg_waddr, .cfg_wdata,
      .tag_head, .tag_empty, .tag_pop, .thr_head, .thr_empty, .thr_pop,
      .alloc_valid, .alloc_thread, .alloc_count,
      .ctx_thread, .ctx_ts, .mshr_tag, .mshr
   );

   ro_fill fill0 (
      .clk, .rstn, .rvalid, .rready, .rid, .rdata, .mshr_tag, .mshr,
      .alloc_valid, .alloc_thread, .alloc_count,
      .edge_valid, .edge_ready, .edge_data, .edge_thread, .edge_last,
      .tag_push, .tag_push_id, .thr_push, .thr_push_id
   );

   ro_child_gen child0 (
      .clk, .rstn, .edge_valid, .edge_ready, .edge_data, .edge_thread, .edge_last,
      .ctx_thread, .ctx_ts, .out_valid, .out_ready, .out_task, .out_last
   );

   free_list #(.ELEM_T(tag_t), .DEPTH(1 << `RO_TAG_BITS)) tag_list (
      .clk, .rstn, .push(tag_push), .push_id(tag_push_id), .pop(tag_pop),
      .head(tag_head), .empty(tag_empty), .full()
   );

   // all threads returned means nothing is in flight
   free_list #(.ELEM_T(thread_t), .DEPTH(`RO_N_THREADS)) thr_list (
      .clk, .rstn, .push(thr_push), .push_id(thr_push_id), .pop(thr_pop),
      .head(thr_head), .empty(thr_empty), .full(idle)
   );

endmodule

// ==== tests/ro_stage_checker.sv ====
`timescale 1ns/1ps

module ro_stage_checker (
   input logic        clk,
   input logic        rstn,
   input logic        arvalid,
   input logic        arready,
   input logic [31:0] araddr,
   input logic [7:0]  arid,
   input logic        out_valid,
   input logic        out_ready,
   input logic [63:0] out_task,
   input logic        out_last
);

   int fail_count = 0;

   // a request waiting for arready keeps its address and id
   ar_hold: assert property (@(posedge clk) disable iff (!rstn)
      arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arid))
      else begin
         $error("read address dropped or changed before arready");
         fail_count++;
      end

   out_hold: assert property (@(posedge clk) disable iff (!rstn)
      out_valid && !out_ready |=> out_valid && $stable(out_task) && $stable(out_last))
      else begin
         $error("child task dropped or changed while stalled");
         fail_count++;
      end

   reset_quiet: assert property (@(posedge clk) !rstn |=> !arvalid && !out_valid)
      else begin
         $error("valid high right after reset");
         fail_count++;
      end

endmodule

// ==== tests/ro_stage_monitor.sv ====
`timescale 1ns/1ps
`include "ro_cfg.svh"

module ro_stage_monitor #(
   parameter logic [31:0] BASE      = 32'h0000_1000,
   parameter int          MEM_EDGES = 512
) (
   input  logic                clk,
   input  logic                rstn,
   input  logic                in_valid,
   input  logic                in_ready,
   input  ro_task_pkg::ro_in_t in_task,
   input  logic                arvalid,
   input  logic                arready,
   input  logic [31:0]         araddr,
   input  logic [7:0]          arid,
   input  logic [7:0]          arlen,
   input  logic                out_valid,
   input  logic                out_ready,
   input  ro_task_pkg::task_t  out_task,
   input  logic                out_last,
   output int                  errors
);
   import ro_task_pkg::*;

   localparam int MAX_CHILD  = 2048;
   localparam int MAX_PARENT = 64;
   localparam logic [7-`RO_TAG_BITS:0] STAGE_ID = `RO_STAGE_ID;

   logic [63:0] edge_mem [MEM_EDGES];   // same contents as the memory model
   logic [31:0] exp_ts [MAX_CHILD];
   logic [31:0] exp_loc [MAX_CHILD];
   int          exp_parent [MAX_CHILD];
   logic        exp_live [MAX_CHILD];
   int          n_exp;
   int          due [MAX_PARENT];       // children still owed per parent
   int          n_parent;
   logic [31:0] ar_q [$];               // line addresses in issue order

   task automatic add_parent(input ro_in_t t);
      edge_t       e;
      logic [31:0] a;
      logic [31:0] first_line;
      logic [31:0] last_line;
      for (int i = int'(t.eo_begin); i < int'(t.eo_end); i++) begin
         e = edge_mem[i];
         exp_ts[n_exp]     = t.task_desc.ts + e.weight;
         exp_loc[n_exp]    = e.neighbor;
         exp_parent[n_exp] = n_parent;
         exp_live[n_exp]   = 1'b1;
         n_exp++;
      end
      due[n_parent] = int'(t.eo_end - t.eo_begin);
      n_parent++;
      first_line = (BASE + (t.eo_begin << 3)) & ~32'h3f;
      last_line  = (BASE + ((t.eo_end - 1) << 3)) & ~32'h3f;
      for (a = first_line; a <= last_line; a += 32'd64) begin
         ar_q.push_back(a);
      end
   endtask

   task automatic check_ar();
      logic [31:0] expected;
      if (ar_q.size() == 0) begin
         errors++;
         $display("read request at %0t for %h with no range outstanding", $time, araddr);
      end else begin
         expected = ar_q.pop_front();
         if (araddr !== expected) begin
            errors++;
            $display("mismatch at %0t: araddr got %h expected %h", $time, araddr, expected);
         end
      end
      if (arlen !== 8'd0) begin
         errors++;
         $display("mismatch at %0t: arlen got %h expected 00", $time, arlen);
      end
      if (arid[7:`RO_TAG_BITS] !== STAGE_ID) begin
         errors++;
         $display("mismatch at %0t: arid stage got %h expected %h",
                  $time, arid[7:`RO_TAG_BITS], STAGE_ID);
      end
   endtask

   task automatic take_child(input task_t c, input logic last);
      int hit;
      int near;
      int p;
      hit  = -1;
      near = -1;
      for (int i = 0; i < n_exp; i++) begin
         if (exp_live[i] && exp_loc[i] == c.locale) begin
            if (exp_ts[i] == c.ts && hit < 0) hit = i;
            else if (near < 0) near = i;
         end
      end
      if (hit < 0) begin
         errors++;
         if (near >= 0)
            $display("mismatch at %0t: out_task.ts got %h expected %h", $time, c.ts, exp_ts[near]);
         else
            $display("child %h at %0t belongs to no outstanding parent", c, $time);
         return;
      end
      exp_live[hit] = 1'b0;
      p = exp_parent[hit];
      due[p]--;
      if (last !== (due[p] == 0)) begin
         errors++;
         $display("mismatch at %0t: out_last got %b expected %b", $time, last, due[p] == 0);
      end
   endtask

   task automatic check_drained();
      for (int p = 0; p < n_parent; p++) begin
         if (due[p] != 0) begin
            errors++;
            $display("parent %0d still misses %0d children", p, due[p]);
         end
      end
      if (ar_q.size() != 0) begin
         errors++;
         $display("%0d line reads were never issued", ar_q.size());
      end
   endtask

   initial begin
      errors   = 0;
      n_exp    = 0;
      n_parent = 0;
   end

   always @(posedge clk) begin
      if (rstn) begin
         if (in_valid && in_ready && in_task.eo_end != in_task.eo_begin) add_parent(in_task);
         if (arvalid && arready) check_ar();
         if (out_valid && out_ready) take_child(out_task, out_last);
      end
   end

endmodule

// ==== tests/ro_stage_tb.sv ====
`timescale 1ns/1ps
`include "ro_cfg.svh"

module ro_stage_tb;
   import ro_task_pkg::*;
   import ro_mem_pkg::*;

   localparam int          N_TASKS        = 60;
   localparam int          MEM_EDGES      = 512;
   localparam logic [31:0] BASE           = 32'h0000_1000;
   localparam int          TIMEOUT_CYCLES = N_TASKS * 400;

   logic                         clk = 1'b0;
   logic                         rstn;
   logic                         in_valid;
   logic                         in_ready;
   ro_in_t                       in_task;
   logic                         arvalid;
   logic                         arready;
   logic [31:0]                  araddr;
   id_t                          arid;
   logic [7:0]                   arlen;
   logic                         rvalid;
   logic                         rready;
   id_t                          rid;
   line_t                        rdata;
   logic                         out_valid;
   logic                         out_ready;
   task_t                        out_task;
   logic                         out_last;
   logic                         cfg_wvalid;
   logic [`RO_CFG_ADDR_BITS-1:0] cfg_waddr;
   logic [31:0]                  cfg_wdata;
   logic                         idle;
   int                           tb_errors;
   int                           mon_errors;
   logic [63:0]                  edge_mem [MEM_EDGES];
   logic [31:0]                  pend_addr [$];   // accepted line reads not yet answered
   logic [7:0]                   pend_id [$];
   logic                         r_taken;

   ro_stage dut0 (
      .clk, .rstn, .in_valid, .in_ready, .in_task, .arvalid, .arready, .araddr, .arid,
      .arlen, .rvalid, .rready, .rid, .rdata, .out_valid, .out_ready, .out_task, .out_last,
      .cfg_wvalid, .cfg_waddr, .cfg_wdata, .idle
   );

   ro_stage_monitor #(.BASE(BASE), .MEM_EDGES(MEM_EDGES)) mon0 (
      .clk, .rstn, .in_valid, .in_ready, .in_task, .arvalid, .arready, .araddr, .arid,
      .arlen, .out_valid, .out_ready, .out_task, .out_last, .errors(mon_errors)
   );

   bind ro_stage ro_stage_checker chk0 (
      .clk, .rstn, .arvalid, .arready, .araddr, .arid,
      .out_valid, .out_ready, .out_task, .out_last
   );

   always #5 clk = ~clk;

   function automatic line_t line_of(input logic [31:0] addr);
      line_t l;
      int    first;
      first = int'((addr - BASE) >> 3);
      for (int i = 0; i < `RO_LINE_EDGES; i++) l[i*64 +: 64] = edge_mem[first + i];
      return l;
   endfunction

   task automatic send_task(input ro_in_t t);
      @(negedge clk);
      in_valid = 1'b1;
      in_task  = t;
      do @(posedge clk); while (!in_ready);
      @(negedge clk);
      in_valid = 1'b0;
   endtask

   always @(posedge clk) begin
      if (rstn && arvalid && arready) begin
         pend_addr.push_back(araddr);
         pend_id.push_back(arid);
      end
      if (rstn && rvalid && rready) r_taken = 1'b1;
   end

   // memory answers in random order, with random gaps
   always @(negedge clk) begin : mem_resp
      int k;
      arready   = ($urandom_range(3) != 0);
      out_ready = ($urandom_range(3) != 0);
      if (r_taken) begin
         rvalid  = 1'b0;
         r_taken = 1'b0;
      end
      if (rstn && !rvalid && pend_addr.size() > 0 && $urandom_range(2) != 0) begin
         k     = $urandom_range(pend_addr.size() - 1);
         rid   = pend_id[k];
         rdata = line_of(pend_addr[k]);
         pend_addr.delete(k);
         pend_id.delete(k);
         rvalid = 1'b1;
      end
   end

   initial begin
      #(TIMEOUT_CYCLES * 10);
      $display("timeout: tasks did not drain within %0d cycles", TIMEOUT_CYCLES);
      $display("*** FAILED ***");
      $finish;
   end

   initial begin
      int unsigned seed;
      int unsigned len;
      ro_in_t      t;
      seed = 32'hcd9d;
      void'($urandom(seed));
      rstn       = 1'b0;
      in_valid   = 1'b0;
      in_task    = '0;
      arready    = 1'b0;
      rvalid     = 1'b0;
      rid        = '0;
      rdata      = '0;
      out_ready  = 1'b0;
      cfg_wvalid = 1'b0;
      cfg_waddr  = '0;
      cfg_wdata  = '0;
      r_taken    = 1'b0;
      tb_errors  = 0;
      for (int i = 0; i < MEM_EDGES; i++) begin
         edge_mem[i]      = {$urandom, $urandom};
         mon0.edge_mem[i] = edge_mem[i];
      end
      repeat (4) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
      @(negedge clk);
      if (idle !== 1'b1) begin
         tb_errors++;
         $display("mismatch at %0t: idle got %b expected 1", $time, idle);
      end
      cfg_wvalid = 1'b1;
      cfg_waddr  = `RO_CFG_NEIGHBOR_BASE;
      cfg_wdata  = BASE >> 2;   // register holds a word address
      @(negedge clk);
      cfg_wvalid = 1'b0;
      for (int n = 0; n < N_TASKS; n++) begin
         len                = ($urandom_range(7) == 0) ? 0 : $urandom_range(20);
         t.task_desc.ts     = $urandom;
         t.task_desc.locale = $urandom;
         t.eo_begin         = $urandom_range(MEM_EDGES - 21);
         t.eo_end           = t.eo_begin + len;
         send_task(t);
         repeat ($urandom_range(2)) @(negedge clk);
      end
      do @(posedge clk); while (!(idle && !out_valid));
      repeat (3) @(negedge clk);
      mon0.check_drained();
      $display("errors: %0d testbench, %0d monitor, %0d assertion",
               tb_errors, mon_errors, dut0.chk0.fail_count);
      if (tb_errors + mon_errors + dut0.chk0.fail_count == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// ==== ro_stage.f ====
+incdir+logic
logic/ro_task_pkg.sv
logic/ro_mem_pkg.sv
logic/free_list.sv
logic/ro_issue.sv
logic/ro_fill.sv
logic/ro_child_gen.sv
logic/ro_stage.sv
tests/ro_stage_checker.sv
tests/ro_stage_monitor.sv
tests/ro_stage_tb.sv
